/* verilog/hub_bus_pkg.sv */
// CPU-side bus definitions for the peripheral hub.
// Address map, request word and the per-register select flags.

package hub_bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // Top address nibble of the peripheral window (0x2xxx_xxxx)
    localparam logic [3:0] PERIPH_REGION = 4'h2;

    // Device number, address bits 15:12
    localparam logic [3:0] DEV_DISPLAY = 4'h1;
    localparam logic [3:0] DEV_UART    = 4'h2;
    localparam logic [3:0] DEV_USB     = 4'h4;
    localparam logic [3:0] DEV_KBD     = 4'h5;

    // Register offsets inside a device, address bits 11:0
    localparam logic [11:0] REG_UART_DATA   = 12'h000;
    localparam logic [11:0] REG_UART_STATUS = 12'h004;
    localparam logic [11:0] REG_USB_VALID   = 12'h000;
    localparam logic [11:0] REG_USB_MSW     = 12'h004;
    localparam logic [11:0] REG_USB_LSW     = 12'h008;
    localparam logic [11:0] REG_KBD_STATUS  = 12'h000;
    localparam logic [11:0] REG_KBD_CODE    = 12'h004;

    // One bus access, valid for a single cycle
    typedef struct packed {
        addr_t      addr;
        logic       we;
        data_t      wdata;
        logic [3:0] be;
    } bus_req_t;

    // Register selects, at most one high per cycle
    typedef struct packed {
        logic display_wr;
        logic uart_tx;
        logic uart_rx;
        logic uart_status;
        logic usb_valid;
        logic usb_msw;
        logic usb_lsw;
        logic kbd_pop;
        logic kbd_status;
        logic kbd_code;
    } dev_sel_t;

endpackage

/* verilog/hub_dev_pkg.sv */
// Device-side types for the UART, USB and PS/2 keyboard paths.
// Status structs are laid out to match their read-back bit positions.

package hub_dev_pkg;

    localparam int BYTE_W = 8;
    localparam int USB_REPORT_W = 64;

    // Scan codes, UART bytes and the display value
    typedef logic [BYTE_W-1:0] byte_t;

    // Most significant word sits in bits 63:32
    typedef logic [USB_REPORT_W-1:0] usb_report_t;

    // UART status register
    //   bit 1: receive data valid
    //   bit 0: transmitter busy
    typedef struct packed {
        logic valid;
        logic busy;
    } uart_status_t;

    // Keyboard status register, bit 0 set while codes are queued
    typedef struct packed {
        logic nonempty;
    } kbd_status_t;

endpackage

/* verilog/periph_decode.sv */
// Address decoder for the peripheral window.
// Turns one bus access into a single register select for the same cycle.

module periph_decode (
    input  hub_bus_pkg::bus_req_t bus_i,
    output hub_bus_pkg::dev_sel_t sel_o
);

    logic [3:0]  region;
    logic [3:0]  dev;
    logic [11:0] offset;

    assign region = bus_i.addr[31:28];
    assign dev    = bus_i.addr[15:12];
    assign offset = bus_i.addr[11:0];

    // No separate read strobe on this bus, a cycle without we is a read.
    // Byte mask is not decoded, every register takes the low bits.
    always_comb begin
        sel_o = '0;
        if (region == hub_bus_pkg::PERIPH_REGION) begin
            case (dev)
                hub_bus_pkg::DEV_DISPLAY: begin
                    // Whole 4 KB page maps to the display
                    sel_o.display_wr = bus_i.we;
                end
                hub_bus_pkg::DEV_UART: begin
                    if (bus_i.we) begin
                        sel_o.uart_tx = (offset == hub_bus_pkg::REG_UART_DATA);
                    end else begin
                        sel_o.uart_rx     = (offset == hub_bus_pkg::REG_UART_DATA);
                        sel_o.uart_status = (offset == hub_bus_pkg::REG_UART_STATUS);
                    end
                end
                hub_bus_pkg::DEV_USB: begin
                    // Read only
                    if (!bus_i.we) begin
                        sel_o.usb_valid = (offset == hub_bus_pkg::REG_USB_VALID);
                        sel_o.usb_msw   = (offset == hub_bus_pkg::REG_USB_MSW);
                        sel_o.usb_lsw   = (offset == hub_bus_pkg::REG_USB_LSW);
                    end
                end
                hub_bus_pkg::DEV_KBD: begin
                    if (bus_i.we) begin
                        // Write to status pops the queue
                        sel_o.kbd_pop = (offset == hub_bus_pkg::REG_KBD_STATUS);
                    end else begin
                        sel_o.kbd_status = (offset == hub_bus_pkg::REG_KBD_STATUS);
                        sel_o.kbd_code   = (offset == hub_bus_pkg::REG_KBD_CODE);
                    end
                end
                default: begin
                end
            endcase
        end

        // Register write side and read mux both rely on a single select
        assert final ($onehot0(sel_o))
            else $error("periph_decode: several selects for addr %h", bus_i.addr);
    end

endmodule

/* verilog/kbd_fifo.sv */
// Circular scan-code queue between the PS/2 input and the CPU.
// Head entry is always visible on rd_data_o; deq_i drops it.

module kbd_fifo #(
    parameter int ADDR_W = 5
) (
    input  logic               clk,
    input  logic               reset_i,
    input  hub_dev_pkg::byte_t wr_data_i,
    input  logic               enq_i,
    input  logic               deq_i,
    output hub_dev_pkg::byte_t rd_data_o,
    output logic               empty_o,
    output logic               full_o
);

    localparam logic [ADDR_W:0] DEPTH = 1 << ADDR_W;
    localparam logic [ADDR_W:0] LAST  = DEPTH - 1'b1;

    hub_dev_pkg::byte_t mem [DEPTH];

    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({enq_i, deq_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (enq_i) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    assign rd_data_o = mem[rd_ptr];
    assign empty_o   = (count == '0);

    // Enqueue requests are registered upstream, so an enqueue in flight
    // counts against the free space. Keeps back-to-back strobes from
    // overrunning the last slot.
    assign full_o = (count == DEPTH) || (enq_i && !deq_i && count == LAST);

    // Upstream flow control must honour full and empty
    assert property (@(posedge clk) disable iff (reset_i) enq_i |-> count != DEPTH)
        else $error("kbd_fifo: enqueue while full");
    assert property (@(posedge clk) disable iff (reset_i) deq_i |-> count != '0)
        else $error("kbd_fifo: dequeue while empty");

endmodule

/* verilog/periph_regs.sv */
// Write-side registers of the peripheral hub.
// Display latch, UART strobes and the keyboard queue with its code register.

module periph_regs #(
    parameter int KBD_FIFO_ADDR_W = 5
) (
    input  logic                     clk,
    input  logic                     reset_i,
    input  hub_bus_pkg::dev_sel_t    sel_i,
    input  hub_bus_pkg::data_t       wdata_i,
    input  hub_dev_pkg::byte_t       kbd_code_i,
    input  logic                     kbd_strobe_i,
    output hub_dev_pkg::byte_t       display_o,
    output logic                     uart_wr_o,
    output logic                     uart_rd_o,
    output hub_dev_pkg::byte_t       uart_tx_data_o,
    output hub_dev_pkg::byte_t       kbd_code_o,
    output hub_dev_pkg::kbd_status_t kbd_status_o
);

    logic               kbd_enq;
    logic               kbd_deq;
    logic               kbd_req_deq;
    hub_dev_pkg::byte_t kbd_wr_data;
    hub_dev_pkg::byte_t fifo_head;
    logic               fifo_empty;
    logic               fifo_full;

    // Pops of an empty queue are ignored here
    assign kbd_req_deq = sel_i.kbd_pop && !fifo_empty;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            display_o  <= '0;
            uart_wr_o  <= 1'b0;
            uart_rd_o  <= 1'b0;
            kbd_enq    <= 1'b0;
            kbd_deq    <= 1'b0;
            kbd_code_o <= '0;
        end else begin
            if (sel_i.display_wr) begin
                display_o <= wdata_i[7:0];
            end

            // One-cycle strobes to the UART core
            uart_wr_o <= sel_i.uart_tx;
            uart_rd_o <= sel_i.uart_rx;

            // Codes arriving on a full queue are lost
            kbd_enq <= kbd_strobe_i && !fifo_full;
            kbd_deq <= kbd_req_deq;

            // Latch the head as it leaves the queue
            if (kbd_deq) begin
                kbd_code_o <= fifo_head;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel_i.uart_tx) begin
            uart_tx_data_o <= wdata_i[7:0];
        end
        // Held for the enqueue one cycle later
        if (kbd_strobe_i) begin
            kbd_wr_data <= kbd_code_i;
        end
    end

    kbd_fifo #(
        .ADDR_W(KBD_FIFO_ADDR_W)
    ) u_kbd_fifo (
        .clk      (clk),
        .reset_i  (reset_i),
        .wr_data_i(kbd_wr_data),
        .enq_i    (kbd_enq),
        .deq_i    (kbd_deq),
        .rd_data_o(fifo_head),
        .empty_o  (fifo_empty),
        .full_o   (fifo_full)
    );

    assign kbd_status_o.nonempty = !fifo_empty;

endmodule

/* verilog/read_mux.sv */
// Read data path of the peripheral hub.
// Picks the selected register and zero-extends it to a bus word.

module read_mux (
    input  hub_bus_pkg::dev_sel_t     sel_i,
    input  hub_dev_pkg::byte_t        uart_rx_data_i,
    input  hub_dev_pkg::uart_status_t uart_status_i,
    input  hub_dev_pkg::usb_report_t  usb_report_i,
    input  logic                      usb_valid_i,
    input  hub_dev_pkg::byte_t        kbd_code_i,
    input  hub_dev_pkg::kbd_status_t  kbd_status_i,
    output hub_bus_pkg::data_t        rdata_o
);

    // Selects are one-hot, so the order below carries no priority.
    // Anything unmapped reads as zero.
    always_comb begin
        rdata_o = '0;
        if (sel_i.uart_rx) begin
            rdata_o = hub_bus_pkg::data_t'(uart_rx_data_i);
        end
        if (sel_i.uart_status) begin
            rdata_o = hub_bus_pkg::data_t'(uart_status_i);
        end
        if (sel_i.usb_valid) begin
            rdata_o = hub_bus_pkg::data_t'(usb_valid_i);
        end
        if (sel_i.usb_msw) begin
            rdata_o = usb_report_i[63:32];
        end
        if (sel_i.usb_lsw) begin
            rdata_o = usb_report_i[31:0];
        end
        if (sel_i.kbd_status) begin
            rdata_o = hub_bus_pkg::data_t'(kbd_status_i);
        end
        if (sel_i.kbd_code) begin
            // Last popped code, not the queue head
            rdata_o = hub_bus_pkg::data_t'(kbd_code_i);
        end
    end

endmodule

/* verilog/periph_hub.sv */
// Peripheral hub top level, the register side of the SoC bus.
// Connects the decoder, write registers and read mux to the outside.

module periph_hub #(
    parameter int KBD_FIFO_ADDR_W = 5
) (
    input  logic                     clk,
    input  logic                     reset_i,

    input  hub_bus_pkg::bus_req_t    bus_i,
    output hub_bus_pkg::data_t       rdata_o,

    output hub_dev_pkg::byte_t       display_o,

    // External UART core
    output logic                     uart_wr_o,
    output logic                     uart_rd_o,
    output hub_dev_pkg::byte_t       uart_tx_data_o,
    input  hub_dev_pkg::byte_t       uart_rx_data_i,
    input  logic                     uart_busy_i,
    input  logic                     uart_valid_i,

    input  hub_dev_pkg::usb_report_t usb_report_i,
    input  logic                     usb_report_valid_i,

    // PS/2 keyboard, error flag has no register yet
    input  hub_dev_pkg::byte_t       kbd_code_i,
    input  logic                     kbd_strobe_i,
    input  logic                     kbd_err_i
);

    hub_bus_pkg::dev_sel_t    sel;
    hub_dev_pkg::byte_t       kbd_code;
    hub_dev_pkg::kbd_status_t kbd_status;

    periph_decode u_decode (
        .bus_i(bus_i),
        .sel_o(sel)
    );

    periph_regs #(
        .KBD_FIFO_ADDR_W(KBD_FIFO_ADDR_W)
    ) u_regs (
        .clk           (clk),
        .reset_i       (reset_i),
        .sel_i         (sel),
        .wdata_i       (bus_i.wdata),
        .kbd_code_i    (kbd_code_i),
        .kbd_strobe_i  (kbd_strobe_i),
        .display_o     (display_o),
        .uart_wr_o     (uart_wr_o),
        .uart_rd_o     (uart_rd_o),
        .uart_tx_data_o(uart_tx_data_o),
        .kbd_code_o    (kbd_code),
        .kbd_status_o  (kbd_status)
    );

    read_mux u_read_mux (
        .sel_i         (sel),
        .uart_rx_data_i(uart_rx_data_i),
        .uart_status_i (hub_dev_pkg::uart_status_t'{valid: uart_valid_i, busy: uart_busy_i}),
        .usb_report_i  (usb_report_i),
        .usb_valid_i   (usb_report_valid_i),
        .kbd_code_i    (kbd_code),
        .kbd_status_i  (kbd_status),
        .rdata_o       (rdata_o)
    );

endmodule

/* testbench/periph_hub_tb.sv */
// Testbench for the peripheral hub.
// Replays testbench/hub_stimulus.txt on the bus and device inputs and checks every response.

module periph_hub_tb;

    localparam int KBD_FIFO_ADDR_W = 5;
    localparam int KBD_DEPTH = 1 << KBD_FIFO_ADDR_W;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLES_PER_LINE = 20;
    localparam string STIM_FILE = "testbench/hub_stimulus.txt";

    logic                     clk;
    logic                     reset_i;
    hub_bus_pkg::bus_req_t    bus_i;
    hub_bus_pkg::data_t       rdata_o;
    hub_dev_pkg::byte_t       display_o;
    logic                     uart_wr_o;
    logic                     uart_rd_o;
    hub_dev_pkg::byte_t       uart_tx_data_o;
    hub_dev_pkg::byte_t       uart_rx_data_i;
    logic                     uart_busy_i;
    logic                     uart_valid_i;
    hub_dev_pkg::usb_report_t usb_report_i;
    logic                     usb_report_valid_i;
    hub_dev_pkg::byte_t       kbd_code_i;
    logic                     kbd_strobe_i;
    logic                     kbd_err_i;

    integer errors;
    integer checks;
    integer tests;
    integer test_errors;
    integer limit_cycles;
    integer seed;
    logic   test_open;
    logic [8*24-1:0] test_name;

    // Codes the keyboard queue should hand back, oldest first
    logic [7:0] kbd_model [$];

    periph_hub #(
        .KBD_FIFO_ADDR_W(KBD_FIFO_ADDR_W)
    ) dut (
        .clk               (clk),
        .reset_i           (reset_i),
        .bus_i             (bus_i),
        .rdata_o           (rdata_o),
        .display_o         (display_o),
        .uart_wr_o         (uart_wr_o),
        .uart_rd_o         (uart_rd_o),
        .uart_tx_data_o    (uart_tx_data_o),
        .uart_rx_data_i    (uart_rx_data_i),
        .uart_busy_i       (uart_busy_i),
        .uart_valid_i      (uart_valid_i),
        .usb_report_i      (usb_report_i),
        .usb_report_valid_i(usb_report_valid_i),
        .kbd_code_i        (kbd_code_i),
        .kbd_strobe_i      (kbd_strobe_i),
        .kbd_err_i         (kbd_err_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic hub_bus_pkg::bus_req_t make_req(input logic [31:0] addr,
                                                        input logic we,
                                                        input logic [31:0] data);
        hub_bus_pkg::bus_req_t req;
        req.addr  = addr;
        req.we    = we;
        req.wdata = data;
        req.be    = 4'hf;
        return req;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
            errors = errors + 1;
            test_errors = test_errors + 1;
        end
    endtask

    task automatic drive_idle();
        bus_i        <= '0;
        kbd_strobe_i <= 1'b0;
    endtask

    task automatic idle(input integer count);
        repeat (count) begin
            @(posedge clk);
            drive_idle();
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        drive_idle();
        bus_i <= make_req(addr, 1'b1, data);
        @(negedge clk);
    endtask

    // Read data is combinational, so it is sampled in the access cycle
    task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp);
        @(posedge clk);
        drive_idle();
        bus_i <= make_req(addr, 1'b0, 32'h0);
        @(negedge clk);
        check_value("rdata_o", rdata_o, exp);
    endtask

    task automatic check_output(input logic [8*16-1:0] sig, input logic [31:0] exp);
        @(posedge clk);
        drive_idle();
        @(negedge clk);
        case (sig)
            "display": check_value("display_o", {24'd0, display_o}, exp);
            "uart_wr": check_value("uart_wr_o", {31'd0, uart_wr_o}, exp);
            "uart_rd": check_value("uart_rd_o", {31'd0, uart_rd_o}, exp);
            "uart_tx": check_value("uart_tx_data_o", {24'd0, uart_tx_data_o}, exp);
            default: begin
                $display("error: stimulus names an output that does not exist: %0s", sig);
                errors = errors + 1;
                test_errors = test_errors + 1;
            end
        endcase
    endtask

    task automatic key_strobe(input logic [7:0] code);
        @(posedge clk);
        drive_idle();
        kbd_strobe_i <= 1'b1;
        kbd_code_i   <= code;
        if (kbd_model.size() < KBD_DEPTH) begin
            kbd_model.push_back(code);
        end
    endtask

    // Back-to-back strobes with random codes
    // Anything beyond the queue depth is lost
    task automatic key_burst(input integer count);
        logic [31:0] rnd;
        for (int i = 0; i < count; i++) begin
            rnd = $random(seed);
            key_strobe(rnd[7:0]);
        end
    endtask

    // Pop request and one spare cycle before the latched code is readable
    task automatic key_pop(input integer count);
        logic [7:0] exp;
        for (int i = 0; i < count; i++) begin
            bus_write({hub_bus_pkg::PERIPH_REGION, 12'h000, hub_bus_pkg::DEV_KBD,
                       hub_bus_pkg::REG_KBD_STATUS}, 32'h0);
            idle(1);
            if (kbd_model.size() == 0) begin
                $display("error: a pop was requested but no code should be queued");
                errors = errors + 1;
                test_errors = test_errors + 1;
                exp = 8'h00;
            end else begin
                exp = kbd_model.pop_front();
            end
            bus_read({hub_bus_pkg::PERIPH_REGION, 12'h000, hub_bus_pkg::DEV_KBD,
                      hub_bus_pkg::REG_KBD_CODE}, {24'd0, exp});
        end
    endtask

    task automatic finish_test();
        if (test_open) begin
            if (test_errors == 0) begin
                $display("test %0s: ok", test_name);
            end else begin
                $display("test %0s: %0d mismatches", test_name, test_errors);
            end
        end
    endtask

    // Watchdog scaled by the number of stimulus lines
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: stimulus did not complete within %0d cycles", limit_cycles);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        integer fd;
        integer rc;
        integer line_count;
        integer n;
        logic [8*8-1:0]   cmd;
        logic [8*16-1:0]  sig;
        logic [8*128-1:0] line;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;

        errors       = 0;
        checks       = 0;
        tests        = 0;
        test_errors  = 0;
        limit_cycles = 0;
        line_count   = 0;
        test_open    = 1'b0;
        test_name    = '0;
        seed         = 32'hb3f0bf32;

        reset_i            = 1'b1;
        bus_i              = '0;
        uart_rx_data_i     = '0;
        uart_busy_i        = 1'b0;
        uart_valid_i       = 1'b0;
        usb_report_i       = '0;
        usb_report_valid_i = 1'b0;
        kbd_code_i         = '0;
        kbd_strobe_i       = 1'b0;
        kbd_err_i          = 1'b0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("error: cannot open the stimulus file %0s", STIM_FILE);
            $display("** FAIL **");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 0) begin
                    line_count = line_count + 1;
                end
            end
            $fclose(fd);
            limit_cycles = line_count * CYCLES_PER_LINE + RESET_CYCLES;
            fd = $fopen(STIM_FILE, "r");

            repeat (RESET_CYCLES) @(posedge clk);
            reset_i <= 1'b0;

            while ($fscanf(fd, "%s", cmd) == 1) begin
                case (cmd)
                    "#": rc = $fgets(line, fd);
                    "T": begin
                        finish_test();
                        rc = $fscanf(fd, "%s", test_name);
                        test_open   = 1'b1;
                        test_errors = 0;
                        tests       = tests + 1;
                    end
                    "W": begin
                        rc = $fscanf(fd, "%h %h", a, b);
                        bus_write(a, b);
                    end
                    "R": begin
                        rc = $fscanf(fd, "%h %h", a, b);
                        bus_read(a, b);
                    end
                    "E": begin
                        rc = $fscanf(fd, "%s %h", sig, a);
                        check_output(sig, a);
                    end
                    "K": begin
                        rc = $fscanf(fd, "%h", a);
                        key_strobe(a[7:0]);
                    end
                    "U": begin
                        rc = $fscanf(fd, "%h %h %h", a, b, c);
                        @(posedge clk);
                        drive_idle();
                        usb_report_i       <= {a, b};
                        usb_report_valid_i <= c[0];
                    end
                    "A": begin
                        rc = $fscanf(fd, "%h %h %h", a, b, c);
                        @(posedge clk);
                        drive_idle();
                        uart_rx_data_i <= a[7:0];
                        uart_busy_i    <= b[0];
                        uart_valid_i   <= c[0];
                    end
                    "Q": begin
                        rc = $fscanf(fd, "%d", n);
                        key_burst(n);
                    end
                    "P": begin
                        rc = $fscanf(fd, "%d", n);
                        key_pop(n);
                    end
                    "I": begin
                        rc = $fscanf(fd, "%d", n);
                        idle(n);
                    end
                    default: begin
                        $display("error: unknown stimulus command %0s", cmd);
                        errors = errors + 1;
                    end
                endcase
            end
            $fclose(fd);

            finish_test();
            $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
            if (errors == 0) begin
                $display("** PASS **");
            end else begin
                $display("** FAIL **");
            end
            $finish;
        end
    end

endmodule

/* testbench/hub_stimulus.txt */
# W addr data | R addr expect | E output expect | K code | U msw lsw valid | A rx busy valid
# T test | Q, P and I take decimal counts, all other fields are hex
T reset
E display 00
E uart_wr 0
E uart_rd 0
R 20005000 00000000
T display
W 20001000 123456a5
E display a5
W 20003000 0000005a
W 20000000 0000005a
W 30001000 0000005a
E display a5
T uart_write
W 20002000 000001c3
E uart_wr 1
E uart_wr 0
E uart_tx c3
T uart_read
A 7e 0 1
R 20002000 0000007e
E uart_rd 1
E uart_rd 0
R 20002004 00000002
A 7e 1 0
R 20002004 00000001
T usb
U deadbeef 01234567 1
R 20004000 00000001
R 20004004 deadbeef
R 20004008 01234567
T kbd_order
K 1c
K 32
K 21
I 2
R 20005000 00000001
P 3
R 20005000 00000000
T kbd_overflow
Q 33
I 4
R 20005000 00000001
P 32
I 2
R 20005000 00000000
T unmapped
R 20002008 00000000
R 2000400c 00000000
R 20005008 00000000
R 20003000 00000000
R 20001000 00000000
R 10004004 00000000

/* files.f */
verilog/hub_bus_pkg.sv
verilog/hub_dev_pkg.sv
verilog/periph_decode.sv
verilog/kbd_fifo.sv
verilog/periph_regs.sv
verilog/read_mux.sv
verilog/periph_hub.sv
testbench/periph_hub_tb.sv

/* Bender.yml */
package:
  name: periph_hub

sources:
  # Packages first, the RTL modules use them by scoped name
  - verilog/hub_bus_pkg.sv
  - verilog/hub_dev_pkg.sv
  - verilog/periph_decode.sv
  - verilog/kbd_fifo.sv
  - verilog/periph_regs.sv
  - verilog/read_mux.sv
  - verilog/periph_hub.sv
  - target: test
    files:
      - testbench/periph_hub_tb.sv
